// File: design/baser_rx_defines.svh
// Width, lock window, bad header limit and error counter width macros
`ifndef BASER_RX_DEFINES_SVH
`define BASER_RX_DEFINES_SVH

// Block format
`define BASER_DATA_W        64  // Scrambled payload bits per block
`define BASER_HDR_W         2   // Sync header bits ahead of the payload

// Block lock
`define BASER_LOCK_WINDOW   64  // Headers per lock window
`define BASER_BAD_HDR_LIMIT 16  // Invalid headers in one window that drop lock

// Statistics
`define BASER_ERR_CNT_W     16  // Each saturating error counter

`endif

// File: design/baser_rx_pkg.sv
// Block, payload union and XGMII word types, XGMII, control and block type codes
`include "baser_rx_defines.svh"

package baser_rx_pkg;

    // Control block payload, code 0 sits just above the block type
    typedef struct packed {
        logic [7:0][6:0] code;
        logic [7:0]      btype;
    } baser_ctrl_view_t;

    typedef union packed {
        logic [`BASER_DATA_W/8-1:0][7:0] data_bytes;  // Byte 0 lowest
        baser_ctrl_view_t                ctrl;
    } baser_payload_u;

    typedef struct packed {
        logic [`BASER_HDR_W-1:0] hdr;
        baser_payload_u          payload;
    } baser_block_t;

    typedef struct packed {
        logic [`BASER_DATA_W-1:0]   rxd;
        logic [`BASER_DATA_W/8-1:0] rxc;  // One flag per byte lane
    } xgmii_word_t;

    // XGMII characters
    localparam logic [7:0] XGMII_IDLE   = 8'h07;
    localparam logic [7:0] XGMII_LPI    = 8'h06;
    localparam logic [7:0] XGMII_START  = 8'hfb;
    localparam logic [7:0] XGMII_TERM   = 8'hfd;
    localparam logic [7:0] XGMII_ERROR  = 8'hfe;
    localparam logic [7:0] XGMII_SEQ_OS = 8'h9c;
    localparam logic [7:0] XGMII_RES_0  = 8'h1c;
    localparam logic [7:0] XGMII_RES_1  = 8'h3c;
    localparam logic [7:0] XGMII_RES_2  = 8'h7c;
    localparam logic [7:0] XGMII_RES_3  = 8'hbc;
    localparam logic [7:0] XGMII_RES_4  = 8'hdc;
    localparam logic [7:0] XGMII_RES_5  = 8'hf7;

    // 7-bit control codes on the line
    localparam logic [6:0] CTRL_IDLE  = 7'h00;
    localparam logic [6:0] CTRL_LPI   = 7'h06;
    localparam logic [6:0] CTRL_ERROR = 7'h1e;
    localparam logic [6:0] CTRL_RES_0 = 7'h2d;
    localparam logic [6:0] CTRL_RES_1 = 7'h33;
    localparam logic [6:0] CTRL_RES_2 = 7'h4b;
    localparam logic [6:0] CTRL_RES_3 = 7'h55;
    localparam logic [6:0] CTRL_RES_4 = 7'h66;
    localparam logic [6:0] CTRL_RES_5 = 7'h78;

    localparam logic [3:0] O_SEQ_OS = 4'h0;  // Only ordered set code accepted

    localparam logic [1:0] SYNC_DATA = 2'b10;
    localparam logic [1:0] SYNC_CTRL = 2'b01;

    // Block types, lanes listed from 7 down to 0
    localparam logic [7:0] BT_CTRL     = 8'h1e;  // C7..C0
    localparam logic [7:0] BT_OS_4     = 8'h2d;  // D7 D6 D5 O4 C3..C0
    localparam logic [7:0] BT_START_4  = 8'h33;  // D7 D6 D5 S4 C3..C0
    localparam logic [7:0] BT_OS_START = 8'h66;  // D7 D6 D5 S4 D3 D2 D1 O0
    localparam logic [7:0] BT_OS_04    = 8'h55;  // D7 D6 D5 O4 D3 D2 D1 O0
    localparam logic [7:0] BT_START_0  = 8'h78;  // D7..D1 S0
    localparam logic [7:0] BT_OS_0     = 8'h4b;  // C7..C4 D3 D2 D1 O0
    localparam logic [7:0] BT_TERM_0   = 8'h87;
    localparam logic [7:0] BT_TERM_1   = 8'h99;
    localparam logic [7:0] BT_TERM_2   = 8'haa;
    localparam logic [7:0] BT_TERM_3   = 8'hb4;
    localparam logic [7:0] BT_TERM_4   = 8'hcc;
    localparam logic [7:0] BT_TERM_5   = 8'hd2;
    localparam logic [7:0] BT_TERM_6   = 8'he1;
    localparam logic [7:0] BT_TERM_7   = 8'hff;

endpackage

// File: design/baser_descrambler.sv
// Self-synchronizing x^58 + x^39 + 1 descrambler, sync header delayed alongside
`timescale 1ns/1ps
`include "baser_rx_defines.svh"

module baser_descrambler (
    input  logic                       clk,
    input  logic                       rst,
    input  baser_rx_pkg::baser_block_t in_block,
    output baser_rx_pkg::baser_block_t out_block
);

    localparam int SCR_LEN = 58;  // Longest tap
    localparam int SCR_TAP = 39;  // Inner tap

    logic [SCR_LEN-1:0]               hist;   // Earlier scrambled bits, MSB newest
    logic [`BASER_DATA_W+SCR_LEN-1:0] ext;    // History below, this block above
    logic [`BASER_DATA_W-1:0]         clear;

    assign ext = {in_block.payload, hist};

    // Bit i of the block lands at ext[SCR_LEN+i]
    always_comb begin
        for (int i = 0; i < `BASER_DATA_W; i++) begin
            clear[i] = ext[SCR_LEN+i] ^ ext[SCR_LEN+i-SCR_TAP] ^ ext[i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hist <= '0;
        end else begin
            hist <= in_block.payload[`BASER_DATA_W-1 -: SCR_LEN];
        end
    end

    always_ff @(posedge clk) begin
        out_block.hdr     <= in_block.hdr;  // Header keeps pace with its payload
        out_block.payload <= clear;
    end

endmodule

// File: design/baser_block_lock.sv
// Block lock FSM with header window counting and slip requests
`timescale 1ns/1ps
`include "baser_rx_defines.svh"

module baser_block_lock (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`BASER_HDR_W-1:0] hdr,
    output logic                    block_lock,
    output logic                    slip
);

    localparam int WIN_W = $clog2(`BASER_LOCK_WINDOW);
    localparam int BAD_W = $clog2(`BASER_BAD_HDR_LIMIT);

    logic [WIN_W-1:0] hdr_cnt;    // Headers seen in the current window
    logic [BAD_W-1:0] bad_cnt;    // Invalid headers in the current window
    logic             hdr_bad;
    logic             win_end;
    logic             bad_limit;

    // Only 01 and 10 are legal sync headers
    assign hdr_bad   = (hdr != baser_rx_pkg::SYNC_DATA) && (hdr != baser_rx_pkg::SYNC_CTRL);
    assign win_end   = hdr_cnt == WIN_W'(`BASER_LOCK_WINDOW - 1);
    assign bad_limit = hdr_bad && (bad_cnt == BAD_W'(`BASER_BAD_HDR_LIMIT - 1));

    // block_lock itself is the FSM state
    always_ff @(posedge clk) begin
        if (rst) begin
            block_lock <= 1'b0;
            slip       <= 1'b0;
            hdr_cnt    <= '0;
            bad_cnt    <= '0;
        end else begin
            slip <= 1'b0;
            if (!block_lock) begin
                bad_cnt <= '0;
                if (hdr_bad) begin
                    slip    <= 1'b1;        // Ask the gearbox to shift by one bit
                    hdr_cnt <= '0;
                end else if (win_end) begin
                    block_lock <= 1'b1;     // Full clean window
                    hdr_cnt    <= '0;
                end else begin
                    hdr_cnt <= hdr_cnt + 1'b1;
                end
            end else if (bad_limit) begin
                // Too many invalid headers, start hunting again
                block_lock <= 1'b0;
                slip       <= 1'b1;
                hdr_cnt    <= '0;
                bad_cnt    <= '0;
            end else if (win_end) begin
                hdr_cnt <= '0;
                bad_cnt <= '0;
            end else begin
                hdr_cnt <= hdr_cnt + 1'b1;
                if (hdr_bad) begin
                    bad_cnt <= bad_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: design/xgmii_baser_dec.sv
// 64b/66b block to XGMII decoder with bad block and sequence error detection
`timescale 1ns/1ps
`include "baser_rx_defines.svh"

module xgmii_baser_dec (
    input  logic                       clk,
    input  logic                       rst,
    input  baser_rx_pkg::baser_block_t block,
    output baser_rx_pkg::xgmii_word_t  xgmii_rx,
    output logic                       bad_block,
    output logic                       seq_error
);

    localparam int LANES = `BASER_DATA_W / 8;

    logic [LANES-1:0][7:0] pay;        // Payload as bytes
    logic [LANES-1:0][7:0] pay_shift;  // Payload bytes moved down past the block type
    logic [LANES-1:0][7:0] dec_ctrl;   // Each control code as an XGMII character
    logic [LANES-1:0]      dec_err;    // Control code with no XGMII meaning
    logic [LANES-1:0][7:0] lane_d;
    logic [LANES-1:0]      lane_c;
    logic [7:0]            btype;
    logic [3:0]            o0;
    logic [3:0]            o4;
    logic [2:0]            term_pos;   // Lane of the terminate character
    logic                  bad_nxt;
    logic                  seq_nxt;
    logic                  frame_nxt;
    logic                  in_frame;

    // Upper bit flags a code that has no mapping
    function automatic logic [8:0] ctrl_char(input logic [6:0] code);
        case (code)
            baser_rx_pkg::CTRL_IDLE:  return {1'b0, baser_rx_pkg::XGMII_IDLE};
            baser_rx_pkg::CTRL_LPI:   return {1'b0, baser_rx_pkg::XGMII_LPI};
            baser_rx_pkg::CTRL_ERROR: return {1'b0, baser_rx_pkg::XGMII_ERROR};
            baser_rx_pkg::CTRL_RES_0: return {1'b0, baser_rx_pkg::XGMII_RES_0};
            baser_rx_pkg::CTRL_RES_1: return {1'b0, baser_rx_pkg::XGMII_RES_1};
            baser_rx_pkg::CTRL_RES_2: return {1'b0, baser_rx_pkg::XGMII_RES_2};
            baser_rx_pkg::CTRL_RES_3: return {1'b0, baser_rx_pkg::XGMII_RES_3};
            baser_rx_pkg::CTRL_RES_4: return {1'b0, baser_rx_pkg::XGMII_RES_4};
            baser_rx_pkg::CTRL_RES_5: return {1'b0, baser_rx_pkg::XGMII_RES_5};
            default:                  return {1'b1, baser_rx_pkg::XGMII_ERROR};
        endcase
    endfunction

    function automatic logic [7:0] os_char(input logic [3:0] ocode);
        if (ocode == baser_rx_pkg::O_SEQ_OS) begin
            return baser_rx_pkg::XGMII_SEQ_OS;
        end
        return baser_rx_pkg::XGMII_ERROR;
    endfunction

    function automatic logic [2:0] term_lane(input logic [7:0] bt);
        case (bt)
            baser_rx_pkg::BT_TERM_1: return 3'd1;
            baser_rx_pkg::BT_TERM_2: return 3'd2;
            baser_rx_pkg::BT_TERM_3: return 3'd3;
            baser_rx_pkg::BT_TERM_4: return 3'd4;
            baser_rx_pkg::BT_TERM_5: return 3'd5;
            baser_rx_pkg::BT_TERM_6: return 3'd6;
            baser_rx_pkg::BT_TERM_7: return 3'd7;
            default:                 return 3'd0;
        endcase
    endfunction

    assign pay       = block.payload.data_bytes;
    assign pay_shift = block.payload >> 8;
    assign btype     = block.payload.ctrl.btype;
    assign o0        = pay[4][3:0];     // Ordered set code in the low half
    assign o4        = pay[4][7:4];
    assign term_pos  = term_lane(btype);

    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            {dec_err[k], dec_ctrl[k]} = ctrl_char(block.payload.ctrl.code[k]);
        end
    end

    always_comb begin
        lane_d    = pay;                // Lanes not set below keep their payload byte
        lane_c    = '0;
        bad_nxt   = 1'b0;
        seq_nxt   = 1'b0;
        frame_nxt = in_frame;

        if (block.hdr == baser_rx_pkg::SYNC_DATA) begin
            // Plain data, nothing to decode
        end else if (block.hdr == baser_rx_pkg::SYNC_CTRL) begin
            case (btype)
                baser_rx_pkg::BT_CTRL: begin
                    lane_d  = dec_ctrl;
                    lane_c  = '1;
                    bad_nxt = |dec_err;
                end
                baser_rx_pkg::BT_OS_4: begin
                    lane_d[3:0] = dec_ctrl[3:0];
                    lane_d[4]   = os_char(o4);
                    lane_c      = 8'h1f;
                    bad_nxt     = (|dec_err[3:0]) || (o4 != baser_rx_pkg::O_SEQ_OS);
                end
                baser_rx_pkg::BT_START_4: begin
                    lane_d[3:0] = dec_ctrl[3:0];
                    lane_d[4]   = baser_rx_pkg::XGMII_START;
                    lane_c      = 8'h1f;
                    bad_nxt     = |dec_err[3:0];
                    seq_nxt     = in_frame;
                    frame_nxt   = 1'b1;
                end
                baser_rx_pkg::BT_OS_START: begin
                    lane_d[0] = os_char(o0);
                    lane_d[4] = baser_rx_pkg::XGMII_START;
                    lane_c    = 8'h11;
                    bad_nxt   = o0 != baser_rx_pkg::O_SEQ_OS;
                    seq_nxt   = in_frame;
                    frame_nxt = 1'b1;
                end
                baser_rx_pkg::BT_OS_04: begin
                    lane_d[0] = os_char(o0);
                    lane_d[4] = os_char(o4);
                    lane_c    = 8'h11;
                    bad_nxt   = (o0 != baser_rx_pkg::O_SEQ_OS) ||
                                (o4 != baser_rx_pkg::O_SEQ_OS);
                end
                baser_rx_pkg::BT_START_0: begin
                    lane_d[0] = baser_rx_pkg::XGMII_START;
                    lane_c    = 8'h01;
                    seq_nxt   = in_frame;
                    frame_nxt = 1'b1;
                end
                baser_rx_pkg::BT_OS_0: begin
                    lane_d[0]   = os_char(o0);
                    lane_d[7:4] = dec_ctrl[7:4];
                    lane_c      = 8'hf1;
                    bad_nxt     = (o0 != baser_rx_pkg::O_SEQ_OS) || (|dec_err[7:4]);
                end
                baser_rx_pkg::BT_TERM_0, baser_rx_pkg::BT_TERM_1,
                baser_rx_pkg::BT_TERM_2, baser_rx_pkg::BT_TERM_3,
                baser_rx_pkg::BT_TERM_4, baser_rx_pkg::BT_TERM_5,
                baser_rx_pkg::BT_TERM_6, baser_rx_pkg::BT_TERM_7: begin
                    // Data below the terminate, control codes above it
                    for (int k = 0; k < LANES; k++) begin
                        if (k < term_pos) begin
                            lane_d[k] = pay_shift[k];
                        end else if (k == term_pos) begin
                            lane_d[k] = baser_rx_pkg::XGMII_TERM;
                            lane_c[k] = 1'b1;
                        end else begin
                            lane_d[k] = dec_ctrl[k];
                            lane_c[k] = 1'b1;
                            bad_nxt   = bad_nxt | dec_err[k];
                        end
                    end
                    seq_nxt   = !in_frame;
                    frame_nxt = 1'b0;
                end
                default: begin
                    lane_d  = {LANES{baser_rx_pkg::XGMII_ERROR}};  // Unknown block type
                    lane_c  = '1;
                    bad_nxt = 1'b1;
                end
            endcase
        end else begin
            lane_d  = {LANES{baser_rx_pkg::XGMII_ERROR}};  // Header 00 or 11
            lane_c  = '1;
            bad_nxt = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            xgmii_rx.rxd <= {LANES{baser_rx_pkg::XGMII_ERROR}};
            xgmii_rx.rxc <= '1;
            bad_block    <= 1'b0;
            seq_error    <= 1'b0;
            in_frame     <= 1'b0;
        end else begin
            xgmii_rx.rxd <= lane_d;
            xgmii_rx.rxc <= lane_c;
            bad_block    <= bad_nxt;
            seq_error    <= seq_nxt;
            in_frame     <= frame_nxt;
        end
    end

endmodule

// File: design/baser_rx_err_count.sv
// Saturating bad block and sequence error counters, active while locked
`timescale 1ns/1ps
`include "baser_rx_defines.svh"

module baser_rx_err_count (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        block_lock,
    input  logic                        bad_block,
    input  logic                        seq_error,
    input  logic                        clr_counts,
    output logic [`BASER_ERR_CNT_W-1:0] bad_block_count,
    output logic [`BASER_ERR_CNT_W-1:0] seq_error_count
);

    localparam int NUM_CNT = 2;

    logic [NUM_CNT-1:0]                       hit;  // Qualified event per counter
    logic [NUM_CNT-1:0][`BASER_ERR_CNT_W-1:0] cnt;

    // Events while unlocked are noise from the alignment search
    assign hit = {seq_error, bad_block} & {NUM_CNT{block_lock}};

    assign bad_block_count = cnt[0];
    assign seq_error_count = cnt[1];

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_CNT; i++) begin
            if (rst || clr_counts) begin
                cnt[i] <= '0;               // Clear wins over a same-cycle event
            end else if (hit[i] && (cnt[i] != '1)) begin
                cnt[i] <= cnt[i] + 1'b1;    // Hold at all ones
            end
        end
    end

endmodule

// File: design/baser_rx_top.sv
// 10GBASE-R receive top with descrambler, block lock, decoder and error counters
`timescale 1ns/1ps
`include "baser_rx_defines.svh"

module baser_rx_top (
    input  logic                        clk,
    input  logic                        rst,
    input  baser_rx_pkg::baser_block_t  rx_block,
    input  logic                        clr_counts,
    output baser_rx_pkg::xgmii_word_t   xgmii_rx,
    output logic                        bad_block,
    output logic                        seq_error,
    output logic                        block_lock,
    output logic                        slip,
    output logic [`BASER_ERR_CNT_W-1:0] bad_block_count,
    output logic [`BASER_ERR_CNT_W-1:0] seq_error_count
);

    baser_rx_pkg::baser_block_t desc_block;  // Descrambled, one cycle behind rx_block

    baser_descrambler i_descrambler (
        .clk       (clk),
        .rst       (rst),
        .in_block  (rx_block),
        .out_block (desc_block)
    );

    // Lock works on the raw headers, ahead of the data path
    baser_block_lock i_block_lock (
        .clk        (clk),
        .rst        (rst),
        .hdr        (rx_block.hdr),
        .block_lock (block_lock),
        .slip       (slip)
    );

    xgmii_baser_dec i_dec (
        .clk       (clk),
        .rst       (rst),
        .block     (desc_block),
        .xgmii_rx  (xgmii_rx),
        .bad_block (bad_block),
        .seq_error (seq_error)
    );

    baser_rx_err_count i_err_count (
        .clk             (clk),
        .rst             (rst),
        .block_lock      (block_lock),
        .bad_block       (bad_block),
        .seq_error       (seq_error),
        .clr_counts      (clr_counts),
        .bad_block_count (bad_block_count),
        .seq_error_count (seq_error_count)
    );

endmodule

// File: verif/baser_rx_tb.sv
// Directed testbench for the 10GBASE-R receive path with scrambler model, tests and watchdog
`timescale 1ns/1ps
`include "baser_rx_defines.svh"

module baser_rx_tb;

    localparam int PERIOD       = 4;
    localparam int BLOCK_BUDGET = 100 + 20 + 30 + 10 + 12 + 160;  // Blocks per test, summed
    localparam int WATCHDOG_NS  = (BLOCK_BUDGET + 5 + 100) * PERIOD;
    localparam logic [63:0] ERR_WORD  = {8{baser_rx_pkg::XGMII_ERROR}};
    localparam logic [63:0] IDLE_WORD = {8{baser_rx_pkg::XGMII_IDLE}};

    typedef struct packed {
        baser_rx_pkg::xgmii_word_t word;
        logic                      bad;
        logic                      seq;
    } expect_t;

    logic                        clk;
    logic                        rst;
    logic                        clr_counts;
    baser_rx_pkg::baser_block_t  rx_block;
    baser_rx_pkg::xgmii_word_t   xgmii_rx;
    logic                        bad_block;
    logic                        seq_error;
    logic                        block_lock;
    logic                        slip;
    logic [`BASER_ERR_CNT_W-1:0] bad_block_count;
    logic [`BASER_ERR_CNT_W-1:0] seq_error_count;

    expect_t     exp_q[$];  // Two blocks in flight through the DUT
    logic [57:0] scr_hist;  // Scrambled bits already sent, newest on top
    integer      seed;
    int          win_pos;   // Header position in the current lock window
    int          errors;
    int          checks;
    int          tests;

    baser_rx_top i_dut (
        .clk             (clk),
        .rst             (rst),
        .rx_block        (rx_block),
        .clr_counts      (clr_counts),
        .xgmii_rx        (xgmii_rx),
        .bad_block       (bad_block),
        .seq_error       (seq_error),
        .block_lock      (block_lock),
        .slip            (slip),
        .bad_block_count (bad_block_count),
        .seq_error_count (seq_error_count)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // s[n] = d[n] ^ s[n-39] ^ s[n-58], bit 0 goes out first
    function automatic logic [63:0] scramble(input logic [63:0] data);
        logic [121:0] ext;
        ext = '0;
        ext[57:0] = scr_hist;
        for (int i = 0; i < 64; i++) begin
            ext[58+i] = data[i] ^ ext[19+i] ^ ext[i];
        end
        scr_hist = ext[121:64];
        return ext[121:58];
    endfunction

    function automatic logic [63:0] random_word();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic expect_t make_expect(input logic [63:0] rxd, input logic [7:0] rxc,
                                            input logic bad, input logic seq);
        expect_t e;
        e.word.rxd = rxd;
        e.word.rxc = rxc;
        e.bad      = bad;
        e.seq      = seq;
        return e;
    endfunction

    // Oldest expected word against what the DUT shows now
    task automatic pop_and_compare();
        expect_t old;
        old = exp_q.pop_front();
        compare_value("xgmii_rx.rxd", xgmii_rx.rxd, old.word.rxd);
        compare_value("xgmii_rx.rxc", xgmii_rx.rxc, old.word.rxc);
        compare_value("bad_block", bad_block, old.bad);
        compare_value("seq_error", seq_error, old.seq);
    endtask

    // Checks the word of two blocks back, then drives the next block
    task automatic send_block(input logic [1:0] hdr, input logic [63:0] data, input expect_t e);
        if (exp_q.size() == 2) begin
            pop_and_compare();
        end
        rx_block.hdr     = hdr;
        rx_block.payload = scramble(data);
        exp_q.push_back(e);
        win_pos = (win_pos + 1) % `BASER_LOCK_WINDOW;
        @(posedge clk);
        #1;
    endtask

    // Last two words, without sending another block
    task automatic flush_in_flight();
        pop_and_compare();
        @(posedge clk);
        #1;
        pop_and_compare();
    endtask

    task automatic send_idle();
        send_block(baser_rx_pkg::SYNC_CTRL, {56'h0, baser_rx_pkg::BT_CTRL},
                   make_expect(IDLE_WORD, 8'hff, 1'b0, 1'b0));
    endtask

    task automatic drain();
        repeat (2) send_idle();
    endtask

    task automatic clear_counts();
        clr_counts = 1'b1;
        send_idle();
        clr_counts = 1'b0;
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        $display("Test %-24s %s (%0d errors)", name,
                 (errors == errs_before) ? "ok" : "failed", errors - errs_before);
    endtask

    task automatic lock_acquire();
        int e0;
        e0 = errors;
        compare_value("xgmii_rx.rxd", xgmii_rx.rxd, ERR_WORD);  // Reset state
        compare_value("xgmii_rx.rxc", xgmii_rx.rxc, 8'hff);
        compare_value("bad_block", bad_block, 1'b0);
        compare_value("seq_error", seq_error, 1'b0);
        compare_value("block_lock", block_lock, 1'b0);
        compare_value("slip", slip, 1'b0);
        compare_value("bad_block_count", bad_block_count, '0);
        compare_value("seq_error_count", seq_error_count, '0);
        repeat (30) send_idle();
        send_block(2'b11, 64'h0, make_expect(ERR_WORD, 8'hff, 1'b1, 1'b0));
        compare_value("slip", slip, 1'b1);  // Window restarts here
        for (int i = 0; i < `BASER_LOCK_WINDOW; i++) begin
            send_idle();
            compare_value("block_lock", block_lock, i == `BASER_LOCK_WINDOW - 1);
            if (i == 0) begin
                compare_value("slip", slip, 1'b0);
            end
        end
        win_pos = 0;
        drain();
        compare_value("bad_block_count", bad_block_count, '0);  // Pulse came while unlocked
        report_test("lock acquisition", e0);
    endtask

    task automatic data_and_idle();
        int          e0;
        logic [63:0] d;
        e0 = errors;
        for (int i = 0; i < 16; i++) begin
            d = random_word();
            if (i % 4 == 3) begin
                send_idle();
            end else begin
                send_block(baser_rx_pkg::SYNC_DATA, d, make_expect(d, 8'h00, 1'b0, 1'b0));
            end
        end
        drain();
        report_test("data and idle", e0);
    endtask

    task automatic frames();
        int          e0;
        logic [63:0] d;
        logic [63:0] pay;
        logic [63:0] rxd;
        logic [7:0]  rxc;
        logic [7:0]  term_bt [8];
        e0 = errors;
        term_bt = '{baser_rx_pkg::BT_TERM_0, baser_rx_pkg::BT_TERM_1, baser_rx_pkg::BT_TERM_2,
                    baser_rx_pkg::BT_TERM_3, baser_rx_pkg::BT_TERM_4, baser_rx_pkg::BT_TERM_5,
                    baser_rx_pkg::BT_TERM_6, baser_rx_pkg::BT_TERM_7};
        for (int t = 0; t < 8; t++) begin
            d = random_word();
            case (t % 3)
                0: send_block(baser_rx_pkg::SYNC_CTRL, {d[63:8], baser_rx_pkg::BT_START_0},
                       make_expect({d[63:8], baser_rx_pkg::XGMII_START}, 8'h01, 1'b0, 1'b0));
                1: send_block(baser_rx_pkg::SYNC_CTRL,
                       {d[63:40], 8'h00, 24'h0, baser_rx_pkg::BT_START_4},
                       make_expect({d[63:40], baser_rx_pkg::XGMII_START, IDLE_WORD[31:0]},
                                   8'h1f, 1'b0, 1'b0));
                default: send_block(baser_rx_pkg::SYNC_CTRL,
                       {d[63:40], 8'h00, d[31:8], baser_rx_pkg::BT_OS_START},
                       make_expect({d[63:40], baser_rx_pkg::XGMII_START, d[31:8],
                                    baser_rx_pkg::XGMII_SEQ_OS}, 8'h11, 1'b0, 1'b0));
            endcase
            d = random_word();
            send_block(baser_rx_pkg::SYNC_DATA, d, make_expect(d, 8'h00, 1'b0, 1'b0));
            d   = random_word();
            pay = {56'h0, term_bt[t]};
            for (int k = 0; k < 8; k++) begin
                rxc[k] = (k >= t);
                if (k < t) begin
                    pay[8*k+8 +: 8] = d[8*k+8 +: 8];  // Data sits one byte above its lane
                    rxd[8*k +: 8]   = d[8*k+8 +: 8];
                end else begin
                    rxd[8*k +: 8] = (k == t) ? baser_rx_pkg::XGMII_TERM : baser_rx_pkg::XGMII_IDLE;
                end
            end
            send_block(baser_rx_pkg::SYNC_CTRL, pay, make_expect(rxd, rxc, 1'b0, 1'b0));
        end
        drain();
        report_test("frames", e0);
    endtask

    task automatic bad_blocks();
        int          e0;
        logic [63:0] d;
        e0 = errors;
        d  = random_word();
        send_block(2'b00, d, make_expect(ERR_WORD, 8'hff, 1'b1, 1'b0));
        send_block(baser_rx_pkg::SYNC_CTRL, {d[63:8], 8'h00},  // Type 0x00 does not exist
                   make_expect(ERR_WORD, 8'hff, 1'b1, 1'b0));
        send_block(baser_rx_pkg::SYNC_CTRL, {28'h0, 7'h11, 21'h0, baser_rx_pkg::BT_CTRL},
                   make_expect({IDLE_WORD[31:0], baser_rx_pkg::XGMII_ERROR, IDLE_WORD[23:0]},
                               8'hff, 1'b1, 1'b0));
        for (int o = 0; o < 2; o++) begin
            send_block(baser_rx_pkg::SYNC_CTRL,
                       {28'h0, (o == 0) ? 4'h5 : 4'h0, d[31:8], baser_rx_pkg::BT_OS_0},
                       make_expect({IDLE_WORD[31:0], d[31:8], (o == 0) ?
                                    baser_rx_pkg::XGMII_ERROR : baser_rx_pkg::XGMII_SEQ_OS},
                                   8'hf1, o == 0, 1'b0));
        end
        drain();
        report_test("bad blocks", e0);
    endtask

    task automatic seq_and_counters();
        int e0;
        e0 = errors;
        clear_counts();
        compare_value("bad_block_count", bad_block_count, '0);
        compare_value("seq_error_count", seq_error_count, '0);
        for (int i = 0; i < 2; i++) begin
            send_block(baser_rx_pkg::SYNC_CTRL, {56'h0, baser_rx_pkg::BT_START_0},
                       make_expect({56'h0, baser_rx_pkg::XGMII_START}, 8'h01, 1'b0, i == 1));
        end
        for (int i = 0; i < 2; i++) begin
            send_block(baser_rx_pkg::SYNC_CTRL, {56'h0, baser_rx_pkg::BT_TERM_0},
                       make_expect({IDLE_WORD[55:0], baser_rx_pkg::XGMII_TERM}, 8'hff,
                                   1'b0, i == 1));
        end
        send_block(baser_rx_pkg::SYNC_CTRL, 64'h0, make_expect(ERR_WORD, 8'hff, 1'b1, 1'b0));
        drain();
        compare_value("bad_block_count", bad_block_count, 1);
        compare_value("seq_error_count", seq_error_count, 2);
        clear_counts();
        compare_value("bad_block_count", bad_block_count, '0);
        compare_value("seq_error_count", seq_error_count, '0);
        report_test("sequence errors, counters", e0);
    endtask

    task automatic lock_loss();
        int e0;
        e0 = errors;
        while (win_pos != 0) begin
            send_idle();
        end
        for (int i = 0; i < 64; i++) begin
            if (i < `BASER_BAD_HDR_LIMIT - 1) begin
                send_block(2'b11, random_word(), make_expect(ERR_WORD, 8'hff, 1'b1, 1'b0));
            end else begin
                send_idle();
            end
            compare_value("block_lock", block_lock, 1'b1);  // One short of the limit
        end
        for (int i = 0; i < `BASER_BAD_HDR_LIMIT; i++) begin
            send_block(2'b00, random_word(), make_expect(ERR_WORD, 8'hff, 1'b1, 1'b0));
            compare_value("block_lock", block_lock, i < `BASER_BAD_HDR_LIMIT - 1);
            compare_value("slip", slip, i == `BASER_BAD_HDR_LIMIT - 1);
        end
        send_idle();
        compare_value("slip", slip, 1'b0);
        compare_value("block_lock", block_lock, 1'b0);
        clear_counts();
        send_block(baser_rx_pkg::SYNC_CTRL, {56'h0, baser_rx_pkg::BT_TERM_0},
                   make_expect({IDLE_WORD[55:0], baser_rx_pkg::XGMII_TERM}, 8'hff,
                               1'b0, 1'b1));
        send_block(2'b00, random_word(), make_expect(ERR_WORD, 8'hff, 1'b1, 1'b0));
        drain();
        compare_value("bad_block_count", bad_block_count, '0);  // Pulses came while unlocked
        compare_value("seq_error_count", seq_error_count, '0);
        flush_in_flight();
        report_test("lock loss", e0);
    endtask

    initial begin
        rst        = 1'b1;
        clr_counts = 1'b0;
        rx_block   = {baser_rx_pkg::SYNC_CTRL, 56'h0, baser_rx_pkg::BT_CTRL};
        scr_hist   = '0;
        seed       = 11;
        win_pos    = 0;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        lock_acquire();
        data_and_idle();
        frames();
        bad_blocks();
        seq_and_counters();
        lock_loss();
        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog sized from the block count of all tests
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: tb.f
+incdir+design
design/baser_rx_pkg.sv
design/baser_descrambler.sv
design/baser_block_lock.sv
design/xgmii_baser_dec.sv
design/baser_rx_err_count.sv
design/baser_rx_top.sv
verif/baser_rx_tb.sv
